// File: logic/nes_mem_macros.svh
`ifndef NES_MEM_MACROS_SVH
`define NES_MEM_MACROS_SVH

// ************************************************
// Widths of the external SRAM
// ************************************************

// Word address width of the 16-bit SRAM
`define SRAM_AW 18
// SRAM data bus, two byte lanes
`define SRAM_DW 16

// ************************************************
// Widths on the console side
// ************************************************

// CPU and PPU move single bytes
`define BYTE_W 8
// Full 6502 address space
`define CPU_AW 16
// PPU address space is 16 KB
`define PPU_AW 14
// Work RAM and nametable RAM are 2 KB each
`define RAM_AW 11

// ************************************************
// Board memory layout
// ************************************************

// Character ROM starts 32 KB into the SRAM, after the program ROM
`define CHR_ROM_OFFSET 'h8000

`endif

// File: logic/nes_mem_pkg.sv
`default_nettype none

package nes_mem_pkg;

	// SRAM access FSM states
	// IDLE keeps every strobe high, READ drops OE, WRITE drops WE for one cycle
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} sram_state_t;

	// Nametable mirroring chosen by the cartridge wiring
	// Horizontal pairs 0x2000/0x2400 and 0x2800/0x2C00
	// Vertical pairs 0x2000/0x2800 and 0x2400/0x2C00
	typedef enum logic
	{
		MIRROR_HORIZONTAL = 1'b0,
		MIRROR_VERTICAL   = 1'b1
	} mirror_mode_t;

endpackage

`default_nettype wire

// File: logic/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module bus_decode
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 ph2_rising,
	input  wire logic                 ph2_falling,
	input  wire logic [`CPU_AW-1:0]   cpu_addr,
	input  wire logic                 cpu_rnw,
	input  wire logic [`PPU_AW-1:0]   ppu_addr,
	input  wire logic                 ppu_rd_req,
	output logic                      cpu_rd_req,
	output logic                      cpu_wr_req,
	output logic                      ppu_sram_rd_req,
	output logic [`SRAM_AW:0]         sram_byte_addr,
	output logic                      work_ram_sel,
	output logic                      nametable_sel
);

	// ************************************************
	// Address decode
	// ************************************************

	logic               cpu_sram_sel;
	logic               cpu_rd_new;
	logic               cpu_rd_pending;
	logic               cpu_rd_defer;
	logic [`SRAM_AW:0]  cpu_byte_addr;
	logic [`SRAM_AW:0]  ppu_byte_addr;

	// Program space is the upper 32 KB of the CPU map
	assign cpu_sram_sel = cpu_addr[15];
	// 0x0000-0x1FFF, mirrors fall out of the 11-bit RAM address
	assign work_ram_sel = (cpu_addr[15:13] == 3'b000);
	// 0x2000-0x3FFF goes to the nametables
	assign nametable_sel = ppu_addr[13];

	// CPU program bytes sit at the bottom of the SRAM
	assign cpu_byte_addr = (`SRAM_AW + 1)'(cpu_addr[14:0]);
	// Pattern tables live behind the program ROM
	assign ppu_byte_addr = (`SRAM_AW + 1)'(ppu_addr[12:0]) +
		(`SRAM_AW + 1)'(`CHR_ROM_OFFSET);

	// ************************************************
	// Request generation and arbitration
	// ************************************************

	// Writes land on ph2 falling, reads start on ph2 rising
	assign cpu_wr_req = ph2_falling && !cpu_rnw && cpu_sram_sel;
	assign cpu_rd_new = ph2_rising && cpu_rnw && cpu_sram_sel;

	// Pattern read wins unless a CPU write owns the cycle
	assign ppu_sram_rd_req = ppu_rd_req && !nametable_sel && !cpu_wr_req;

	// A CPU read that lost last cycle is still waiting
	assign cpu_rd_pending = cpu_rd_new || cpu_rd_defer;
	assign cpu_rd_req = cpu_rd_pending && !ppu_sram_rd_req;

	// Park the CPU read for a cycle when the PPU takes the SRAM
	always_ff @(posedge clk)
	begin
		if (rst)
			cpu_rd_defer <= 1'b0;
		else
			cpu_rd_defer <= cpu_rd_pending && ppu_sram_rd_req;
	end

	// Address of whichever request got the SRAM
	always_comb
	begin
		if (ppu_sram_rd_req)
			sram_byte_addr = ppu_byte_addr;
		else
			sram_byte_addr = cpu_byte_addr;
	end

	// Deferred read must never meet a write on the same cycle
	cpu_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(cpu_rd_req && cpu_wr_req));

endmodule

`default_nettype wire

// File: logic/sram_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module sram_issue import nes_mem_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 cpu_rd_req,
	input  wire logic                 cpu_wr_req,
	input  wire logic                 ppu_sram_rd_req,
	input  wire logic [`SRAM_AW:0]    sram_byte_addr,
	input  wire logic [`BYTE_W-1:0]   cpu_data_in,
	output logic                      sram_csn,
	output logic                      sram_oen,
	output logic                      sram_wen,
	output logic                      sram_lbn,
	output logic                      sram_hbn,
	output logic [`SRAM_AW-1:0]       sram_addr,
	output logic [`SRAM_DW-1:0]       sram_data_out,
	output logic [`SRAM_DW-1:0]       sram_data_t,
	output sram_state_t               sram_state,
	output logic                      lane_sel,
	output logic                      cpu_read_issued
);

	sram_state_t  state_next;
	logic         lane_q;
	logic         cpu_rd_q;

	// ************************************************
	// Access FSM
	// ************************************************

	// Write has priority over any read and IDLE releases the bus
	always_comb
	begin
		if (cpu_wr_req)
			state_next = WRITE;
		else if (cpu_rd_req || ppu_sram_rd_req)
			state_next = READ;
		else
			state_next = IDLE;
	end

	// Strobes come straight from flops for clean pad timing
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sram_state      <= IDLE;
			sram_csn        <= 1'b1;
			sram_oen        <= 1'b1;
			sram_wen        <= 1'b1;
			sram_lbn        <= 1'b1;
			sram_hbn        <= 1'b1;
			sram_data_t     <= '1;
			cpu_rd_q        <= 1'b0;
			cpu_read_issued <= 1'b0;
		end
		else
		begin
			sram_state  <= state_next;
			sram_csn    <= (state_next == IDLE);
			sram_oen    <= (state_next != READ);
			sram_wen    <= (state_next != WRITE);
			// Drive the data pins only while writing
			sram_data_t <= {`SRAM_DW{state_next != WRITE}};
			// Byte address bit 0 picks the upper lane
			sram_lbn    <= (state_next == IDLE) || sram_byte_addr[0];
			sram_hbn    <= (state_next == IDLE) || !sram_byte_addr[0];
			cpu_rd_q    <= cpu_rd_req;
			// Marker lines up with the captured SRAM word
			cpu_read_issued <= cpu_rd_q;
		end
	end

	// ************************************************
	// Address, data and lane pipeline
	// ************************************************

	always_ff @(posedge clk)
	begin
		// Address holds between accesses
		if (state_next != IDLE)
			sram_addr <= sram_byte_addr[`SRAM_AW:1];
		// Same byte on both halves so the mask picks the lane
		if (cpu_wr_req)
			sram_data_out <= {2{cpu_data_in}};
		lane_q   <= sram_byte_addr[0];
		lane_sel <= lane_q;
	end

	// A read arriving with a write would be lost to the write priority
	wr_rd_excl: assert property (@(posedge clk) disable iff (rst)
		cpu_wr_req |-> !(cpu_rd_req || ppu_sram_rd_req));

	// Write pulse is one cycle wide
	we_single: assert property (@(posedge clk) disable iff (rst)
		!sram_wen |=> sram_wen);

endmodule

`default_nettype wire

// File: logic/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module work_ram
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 ph2_rising,
	input  wire logic                 ph2_falling,
	input  wire logic                 work_ram_sel,
	input  wire logic                 cpu_rnw,
	input  wire logic [`RAM_AW-1:0]   cpu_addr,
	input  wire logic [`BYTE_W-1:0]   cpu_data_in,
	output logic [`BYTE_W-1:0]        work_ram_dout,
	output logic                      work_ram_ack
);

	// 2 KB of CPU RAM, inferred as block RAM
	logic [`BYTE_W-1:0] mem [2**`RAM_AW];

	// Read strobe acknowledged one cycle later, data is ready by then
	always_ff @(posedge clk)
	begin
		if (rst)
			work_ram_ack <= 1'b0;
		else
			work_ram_ack <= ph2_rising && cpu_rnw && work_ram_sel;
	end

	// Synchronous read, write on the falling ph2 edge
	always_ff @(posedge clk)
	begin
		if (work_ram_sel)
		begin
			if (ph2_falling && !cpu_rnw)
				mem[cpu_addr] <= cpu_data_in;
			work_ram_dout <= mem[cpu_addr];
		end
	end

endmodule

`default_nettype wire

// File: logic/nametable_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module nametable_ram import nes_mem_pkg::*;
#(
	parameter mirror_mode_t MIRRORING = MIRROR_VERTICAL
)
(
	input  wire logic                 clk,
	input  wire logic                 nametable_sel,
	input  wire logic                 ppu_wr_req,
	input  wire logic [`PPU_AW-1:0]   ppu_addr,
	input  wire logic [`BYTE_W-1:0]   ppu_din,
	output logic [`BYTE_W-1:0]        nametable_dout
);

	// Two physical 1 KB tables behind four logical ones
	logic [`BYTE_W-1:0] mem [2**`RAM_AW];
	logic [`BYTE_W-1:0] rd_q;
	logic               table_sel;
	logic [`RAM_AW-1:0] ram_addr;

	// Horizontal folds on A11, vertical on A10
	assign table_sel = (MIRRORING == MIRROR_HORIZONTAL) ? ppu_addr[11] : ppu_addr[10];
	assign ram_addr = {table_sel, ppu_addr[9:0]};

	// Two read registers, frozen while the PPU looks elsewhere
	always_ff @(posedge clk)
	begin
		if (nametable_sel)
		begin
			if (ppu_wr_req)
				mem[ram_addr] <= ppu_din;
			rd_q           <= mem[ram_addr];
			nametable_dout <= rd_q;
		end
	end

endmodule

`default_nettype wire

// File: logic/read_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module read_return import nes_mem_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 ph2_falling,
	input  wire sram_state_t          sram_state,
	input  wire logic [`SRAM_DW-1:0]  sram_data_in,
	input  wire logic                 lane_sel,
	input  wire logic                 cpu_read_issued,
	input  wire logic                 work_ram_ack,
	input  wire logic [`BYTE_W-1:0]   work_ram_dout,
	input  wire logic                 nametable_sel,
	input  wire logic [`BYTE_W-1:0]   nametable_dout,
	output logic [`BYTE_W-1:0]        cpu_data_out,
	output logic [`BYTE_W-1:0]        ppu_dout
);

	logic [`SRAM_DW-1:0] sram_word_q;
	logic [`BYTE_W-1:0]  sram_byte;
	logic [`BYTE_W-1:0]  ppu_byte_q;
	logic                rd_done;

	// ************************************************
	// SRAM capture
	// ************************************************

	// Word sampled at the end of the READ cycle
	always_ff @(posedge clk)
	begin
		if (sram_state == READ)
			sram_word_q <= sram_data_in;
	end

	// Flags a fresh word in sram_word_q
	always_ff @(posedge clk)
	begin
		if (rst)
			rd_done <= 1'b0;
		else
			rd_done <= (sram_state == READ);
	end

	assign sram_byte = lane_sel ? sram_word_q[15:8] : sram_word_q[7:0];

	// ************************************************
	// CPU and PPU data buses
	// ************************************************

	// CPU byte sits on the bus until ph2 ends and reads zero otherwise
	always_ff @(posedge clk)
	begin
		if (rst || ph2_falling)
			cpu_data_out <= '0;
		else if (rd_done && cpu_read_issued)
			cpu_data_out <= sram_byte;
		else if (work_ram_ack)
			cpu_data_out <= work_ram_dout;
	end

	// Pattern byte holds until the next PPU SRAM read
	always_ff @(posedge clk)
	begin
		if (rd_done && !cpu_read_issued)
			ppu_byte_q <= sram_byte;
	end

	assign ppu_dout = nametable_sel ? nametable_dout : ppu_byte_q;

endmodule

`default_nettype wire

// File: logic/nes_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module nes_mem_top import nes_mem_pkg::*;
#(
	parameter mirror_mode_t MIRRORING = MIRROR_VERTICAL
)
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 ph2_rising,
	input  wire logic                 ph2_falling,
	// External SRAM
	output logic                      sram_csn,
	output logic                      sram_oen,
	output logic                      sram_wen,
	output logic                      sram_lbn,
	output logic                      sram_hbn,
	output logic [`SRAM_AW-1:0]       sram_addr,
	input  wire logic [`SRAM_DW-1:0]  sram_data_in,
	output logic [`SRAM_DW-1:0]       sram_data_out,
	output logic [`SRAM_DW-1:0]       sram_data_t,
	// CPU side
	input  wire logic [`CPU_AW-1:0]   cpu_addr,
	input  wire logic                 cpu_rnw,
	input  wire logic [`BYTE_W-1:0]   cpu_data_in,
	output logic [`BYTE_W-1:0]        cpu_data_out,
	// PPU side
	input  wire logic [`PPU_AW-1:0]   ppu_addr,
	input  wire logic                 ppu_rd_req,
	input  wire logic                 ppu_wr_req,
	input  wire logic [`BYTE_W-1:0]   ppu_din,
	output logic [`BYTE_W-1:0]        ppu_dout
);

	logic                cpu_rd_req;
	logic                cpu_wr_req;
	logic                ppu_sram_rd_req;
	logic [`SRAM_AW:0]   sram_byte_addr;
	logic                work_ram_sel;
	logic                nametable_sel;
	sram_state_t         sram_state;
	logic                lane_sel;
	logic                cpu_read_issued;
	logic [`BYTE_W-1:0]  work_ram_dout;
	logic                work_ram_ack;
	logic [`BYTE_W-1:0]  nametable_dout;

	// Stage 1, decode and arbitration
	bus_decode i_bus_decode (
		.clk, .rst, .ph2_rising, .ph2_falling, .cpu_addr, .cpu_rnw, .ppu_addr,
		.ppu_rd_req, .cpu_rd_req, .cpu_wr_req, .ppu_sram_rd_req, .sram_byte_addr,
		.work_ram_sel, .nametable_sel
	);

	// Stage 2, SRAM pins
	sram_issue i_sram_issue (
		.clk, .rst, .cpu_rd_req, .cpu_wr_req, .ppu_sram_rd_req, .sram_byte_addr,
		.cpu_data_in, .sram_csn, .sram_oen, .sram_wen, .sram_lbn, .sram_hbn,
		.sram_addr, .sram_data_out, .sram_data_t, .sram_state, .lane_sel,
		.cpu_read_issued
	);

	work_ram i_work_ram (
		.clk, .rst, .ph2_rising, .ph2_falling, .work_ram_sel, .cpu_rnw,
		.cpu_addr(cpu_addr[`RAM_AW-1:0]), .cpu_data_in, .work_ram_dout, .work_ram_ack
	);

	nametable_ram #(.MIRRORING(MIRRORING)) i_nametable_ram (
		.clk, .nametable_sel, .ppu_wr_req, .ppu_addr, .ppu_din, .nametable_dout
	);

	// Stage 3, data back to CPU and PPU
	read_return i_read_return (
		.clk, .rst, .ph2_falling, .sram_state, .sram_data_in, .lane_sel,
		.cpu_read_issued, .work_ram_ack, .work_ram_dout, .nametable_sel,
		.nametable_dout, .cpu_data_out, .ppu_dout
	);

endmodule

`default_nettype wire

// File: sim/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module sram_model
(
	input  wire logic                 clk,
	input  wire logic                 csn,
	input  wire logic                 oen,
	input  wire logic                 wen,
	input  wire logic                 lbn,
	input  wire logic                 hbn,
	input  wire logic [`SRAM_AW-1:0]  addr,
	input  wire logic [`SRAM_DW-1:0]  wdata,
	output logic [`SRAM_DW-1:0]       rdata
);

	// Whole 256K x 16 array
	logic [`SRAM_DW-1:0] mem [2**`SRAM_AW];

	// Asynchronous read, each byte lane gated by its own mask
	assign rdata = {
		(!csn && !oen && !hbn) ? mem[addr][15:8] : 8'hzz,
		(!csn && !oen && !lbn) ? mem[addr][7:0] : 8'hzz
	};

	// Write lands when the WE pulse ends, which is the next clock edge
	always @(posedge clk)
	begin
		if (!csn && !wen)
		begin
			if (!lbn)
				mem[addr][7:0] <= wdata[7:0];
			if (!hbn)
				mem[addr][15:8] <= wdata[15:8];
		end
	end

	// Backdoor load for the initial image
	task automatic load_word(input int word_addr, input logic [`SRAM_DW-1:0] value);
		mem[word_addr] = value;
	endtask

endmodule

`default_nettype wire

// File: sim/tb_nes_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "nes_mem_macros.svh"

module tb_nes_mem import nes_mem_pkg::*;
();

	// Words 0x0000-0x4FFF hold program bytes and the pattern tables
	localparam int PRELOAD_WORDS = 'h5000;
	localparam int MAX_OPS = 64;
	localparam int COLS = 5;
	// Expected column value that selects the byte from the shadow image
	localparam logic [15:0] FROM_SHADOW = 16'h0100;
	localparam logic [15:0] OP_CPU_WR = 16'd0;
	localparam logic [15:0] OP_CPU_RD = 16'd1;
	localparam logic [15:0] OP_PPU_WR = 16'd2;
	localparam logic [15:0] OP_PPU_RD = 16'd3;
	localparam logic [15:0] OP_BOTH_RD = 16'd4;

	logic                clk;
	logic                rst;
	logic                ph2_rising;
	logic                ph2_falling;
	logic                sram_csn;
	logic                sram_oen;
	logic                sram_wen;
	logic                sram_lbn;
	logic                sram_hbn;
	logic [`SRAM_AW-1:0] sram_addr;
	logic [`SRAM_DW-1:0] sram_data_in;
	logic [`SRAM_DW-1:0] sram_data_out;
	logic [`SRAM_DW-1:0] sram_data_t;
	logic [`CPU_AW-1:0]  cpu_addr;
	logic                cpu_rnw;
	logic [`BYTE_W-1:0]  cpu_data_in;
	logic [`BYTE_W-1:0]  cpu_data_out;
	logic [`PPU_AW-1:0]  ppu_addr;
	logic                ppu_rd_req;
	logic                ppu_wr_req;
	logic [`BYTE_W-1:0]  ppu_din;
	logic [`BYTE_W-1:0]  ppu_dout;

	// Copy of the SRAM image that follows CPU writes
	logic [15:0] shadow [PRELOAD_WORDS];
	// Operation list with five columns per line
	logic [15:0] ops [MAX_OPS*COLS];
	int          op_count;
	logic        loaded;
	int          mismatches;
	int          failures;

	nes_mem_top #(.MIRRORING(MIRROR_VERTICAL)) i_nes_mem_top (
		.clk, .rst, .ph2_rising, .ph2_falling, .sram_csn, .sram_oen, .sram_wen,
		.sram_lbn, .sram_hbn, .sram_addr, .sram_data_in, .sram_data_out, .sram_data_t,
		.cpu_addr, .cpu_rnw, .cpu_data_in, .cpu_data_out, .ppu_addr, .ppu_rd_req,
		.ppu_wr_req, .ppu_din, .ppu_dout
	);

	sram_model i_sram (
		.clk, .csn(sram_csn), .oen(sram_oen), .wen(sram_wen), .lbn(sram_lbn),
		.hbn(sram_hbn), .addr(sram_addr), .wdata(sram_data_out), .rdata(sram_data_in)
	);

	// 8 ns clock
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// **************************************************
	// Helpers
	// **************************************************

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Word is byte address >> 1
	// Odd bytes sit in the upper lane
	function automatic logic [7:0] lookup_byte(input int byte_addr);
		logic [15:0] word;
		word = shadow[byte_addr >> 1];
		return byte_addr[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic note_write(input int byte_addr, input logic [7:0] value);
		if (byte_addr[0])
			shadow[byte_addr >> 1][15:8] = value;
		else
			shadow[byte_addr >> 1][7:0] = value;
	endtask

	// Seven cycles per line of the list
	task automatic run_op(input int idx);
		logic [15:0] op;
		logic [15:0] addr;
		logic [15:0] addr2;
		logic [15:0] data;
		logic [15:0] exp_col;
		logic [13:0] ppu_a;
		logic [7:0]  exp_cpu;
		logic [7:0]  exp_ppu;
		logic        cpu_op;
		int          cyc;
		op = ops[idx*COLS];
		addr = ops[idx*COLS+1];
		addr2 = ops[idx*COLS+2];
		data = ops[idx*COLS+3];
		exp_col = ops[idx*COLS+4];
		cpu_op = (op == OP_CPU_WR) || (op == OP_CPU_RD) || (op == OP_BOTH_RD);
		ppu_a = (op == OP_BOTH_RD) ? addr2[13:0] : addr[13:0];
		// CPU program bytes start at SRAM byte 0
		exp_cpu = (exp_col == FROM_SHADOW) ? lookup_byte(int'(addr[14:0])) : exp_col[7:0];
		// Pattern bytes sit behind the character ROM offset
		if (op == OP_BOTH_RD || exp_col == FROM_SHADOW)
			exp_ppu = lookup_byte(`CHR_ROM_OFFSET + int'(ppu_a[12:0]));
		else
			exp_ppu = exp_col[7:0];

		@(negedge clk);
		if (cpu_op)
		begin
			cpu_addr = addr;
			cpu_rnw = (op != OP_CPU_WR);
			cpu_data_in = data[7:0];
			ph2_rising = 1'b1;
		end
		if (op == OP_PPU_WR || op == OP_PPU_RD || op == OP_BOTH_RD)
		begin
			ppu_addr = ppu_a;
			ppu_din = data[7:0];
			ppu_wr_req = (op == OP_PPU_WR);
			ppu_rd_req = (op != OP_PPU_WR);
		end

		for (cyc = 1; cyc <= 7; cyc++)
		begin
			@(negedge clk);
			// Strobes and requests are single cycle
			if (cyc == 1)
			begin
				ph2_rising = 1'b0;
				ppu_rd_req = 1'b0;
				ppu_wr_req = 1'b0;
			end
			if (cyc == 5 && (op == OP_PPU_RD || op == OP_BOTH_RD))
				check_value("ppu_dout", ppu_dout, exp_ppu);
			// CPU byte must be on the bus in the last cycle of ph2
			if (cyc == 6 && cpu_op)
			begin
				if (op != OP_CPU_WR)
					check_value("cpu_data_out", cpu_data_out, exp_cpu);
				ph2_falling = 1'b1;
			end
			if (cyc == 7)
				ph2_falling = 1'b0;
		end

		if (op == OP_CPU_WR && addr[15])
			note_write(int'(addr[14:0]), data[7:0]);
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial
	begin
		logic [31:0] rnd;
		int          i;
		rst = 1'b1;
		ph2_rising = 1'b0;
		ph2_falling = 1'b0;
		cpu_addr = '0;
		cpu_rnw = 1'b1;
		cpu_data_in = '0;
		ppu_addr = '0;
		ppu_rd_req = 1'b0;
		ppu_wr_req = 1'b0;
		ppu_din = '0;
		mismatches = 0;
		failures = 0;
		op_count = 0;
		loaded = 1'b0;

		rnd = $urandom(32'h1ac9);
		// Random image in the model and the same values in the shadow
		for (i = 0; i < PRELOAD_WORDS; i++)
		begin
			rnd = $urandom;
			shadow[i] = rnd[15:0];
			i_sram.load_word(i, rnd[15:0]);
		end

		// All ones in the op column marks the end of the list
		for (i = 0; i < MAX_OPS*COLS; i++)
			ops[i] = 16'hffff;
		$readmemh("sim/mem_input.txt", ops);
		while (op_count < MAX_OPS && ops[op_count*COLS] != 16'hffff)
			op_count++;
		loaded = 1'b1;
		if (op_count == 0)
		begin
			failures++;
			$display("No operations were read from sim/mem_input.txt");
		end

		repeat (16) @(negedge clk);
		rst = 1'b0;
		// Reset values, sampled before the first active edge
		check_value("sram_csn", 16'(sram_csn), 16'h1);
		check_value("sram_oen", 16'(sram_oen), 16'h1);
		check_value("sram_wen", 16'(sram_wen), 16'h1);
		check_value("sram_lbn", 16'(sram_lbn), 16'h1);
		check_value("sram_hbn", 16'(sram_hbn), 16'h1);
		check_value("sram_data_t", sram_data_t, 16'hffff);
		check_value("cpu_data_out", 16'(cpu_data_out), 16'h0);

		for (i = 0; i < op_count; i++)
			run_op(i);
		repeat (4) @(negedge clk);

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog budget grows with the length of the list
	initial
	begin
		wait (loaded);
		repeat (op_count * 20 + 100) @(posedge clk);
		failures++;
		$display("Timeout: the operation list did not complete in %0d cycles",
			op_count * 20 + 100);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/mem_input.txt
// Columns: op addr addr2 data expect, all hex. op 0 CPU write, 1 CPU read, 2 PPU write,
// 3 PPU read, 4 CPU and PPU read together (addr2 is the PPU address). expect 100 = SRAM shadow
0 8101 0000 a5 00
1 8100 0000 00 100
1 8101 0000 00 a5
0 8200 0000 3c 00
1 8201 0000 00 100
1 8200 0000 00 3c
0 0005 0000 77 00
1 0805 0000 00 77
1 1805 0000 00 77
3 0123 0000 00 100
3 1ffe 0000 00 100
2 2010 0000 5a 00
3 2810 0000 00 5a
2 2410 0000 c3 00
3 2010 0000 00 5a
3 2c10 0000 00 c3
4 8101 0044 00 a5
4 8201 0045 00 100

// File: all.f
+incdir+logic
logic/nes_mem_pkg.sv
logic/bus_decode.sv
logic/sram_issue.sv
logic/work_ram.sv
logic/nametable_ram.sv
logic/read_return.sv
logic/nes_mem_top.sv
sim/sram_model.sv
sim/tb_nes_mem.sv

// File: Bender.yml
package:
  name: nes_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/nes_mem_pkg.sv
      - logic/bus_decode.sv
      - logic/sram_issue.sv
      - logic/work_ram.sv
      - logic/nametable_ram.sv
      - logic/read_return.sv
      - logic/nes_mem_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/sram_model.sv
      - sim/tb_nes_mem.sv
